//--- all.f
hw/vmaPkg.sv
hw/pcFlags.sv
hw/vmaReg.sv
hw/pageCheck.sv
hw/vmaTop.sv
verification/vmaChecker.sv
verification/vmaTb.sv

//--- hw/pageCheck.sv
//////////////////////////////
// Small page table
// Access check and page fail pulse
//////////////////////////////

`timescale 1ns/1ps

module pageCheck #(
   parameter int pageIndexBits = 4
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clken,
   input  logic                         pageWrite,
   input  logic                         pageValid,
   input  logic                         pageWritable,
   input  logic                         pageUserOk,
   input  logic [pageIndexBits-1:0]     pageIndex,
   input  logic [vmaPkg::wordWidth-1:0] vmaOut,
   input  logic                         vmaLoad,
   output logic                         pageFail
);

   import vmaPkg::*;

   localparam int tableSize = 1 << pageIndexBits;
   // Page number sits above the word offset
   localparam int pageNumLo = vmaAddrLo + pageOffsetBits;

   //////////////////////////////
   // Page table
   //////////////////////////////

   logic [tableSize-1:0]     entryValid;
   logic [tableSize-1:0]     entryWritable;
   logic [tableSize-1:0]     entryUserOk;
   logic [pageIndexBits-1:0] lookupIndex;
   logic                     checkEn;
   logic                     writeAccess;
   logic                     fault;

   // Valid bits clear on reset
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         entryValid <= '0;
      end
      else if (clken && pageWrite)
      begin
         entryValid[pageIndex] <= pageValid;
      end
   end

   // Permission bits
   always_ff @(posedge clk)
   begin
      if (clken && pageWrite)
      begin
         entryWritable[pageIndex] <= pageWritable;
         entryUserOk[pageIndex]   <= pageUserOk;
      end
   end

   //////////////////////////////
   // Access check
   //////////////////////////////

   // Low bits of the page number
   assign lookupIndex = vmaOut[pageNumLo +: pageIndexBits];

   // Physical and io accesses bypass the table
   assign checkEn     = !vmaOut[vmaPhys] && !vmaOut[vmaIo];
   assign writeAccess = vmaOut[vmaWrite] || vmaOut[vmaWrTest];

   assign fault = !entryValid[lookupIndex] ||
                  (writeAccess && !entryWritable[lookupIndex]) ||
                  (vmaOut[vmaUser] && !entryUserOk[lookupIndex]);

   // One cycle after a load with a bad VMA
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pageFail <= 1'b0;
      end
      else if (clken)
      begin
         pageFail <= vmaLoad && checkEn && fault;
      end
   end

endmodule

//--- hw/pcFlags.sv
//////////////////////////////
// Processor flags register
// User and previous-context user
//////////////////////////////

`timescale 1ns/1ps

module pcFlags (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clken,
   input  logic                         flagsLoad,
   input  logic [vmaPkg::cromWidth-1:0] crom,
   input  logic [vmaPkg::wordWidth-1:0] dp,
   output logic                         flagUser,
   output logic                         flagPcu
);

   import vmaPkg::*;

   specSelT specSel;
   logic    loadFlagsFn;
   logic    flagsStrobe;

   // Local decode of the load-flags special function
   assign specSel     = specSelT'(crom[cromSpecSelLo +: specSelWidth]);
   assign loadFlagsFn = crom[cromSpecEn] && (specSel == specLoadFlags);

   // Either the external strobe or microcode
   assign flagsStrobe = flagsLoad || loadFlagsFn;

   //////////////////////////////
   // Flag register
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         flagUser <= 1'b0;
         flagPcu  <= 1'b0;
      end
      else if (clken && flagsStrobe)
      begin
         // Same positions as the VMA user and prev bits
         flagUser <= dp[vmaUser];
         flagPcu  <= dp[vmaPrev];
      end
   end

endmodule

//--- hw/vmaPkg.sv
//////////////////////////////
// VMA stage shared definitions
// Widths, microword, dispatch and VMA bit positions, enums
//////////////////////////////

package vmaPkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   // Narrowed microword and dispatch word
   localparam int cromWidth = 21;
   localparam int dromWidth = 5;
   // Data path and VMA
   localparam int wordWidth = 36;
   localparam int addrWidth = 22;
   // Address field starts above the flag bits
   localparam int vmaAddrLo = 14;
   // Word offset inside a page
   localparam int pageOffsetBits = 9;
   localparam int cycleSelWidth = 2;
   localparam int specSelWidth = 3;

   //////////////////////////////
   // Microword fields
   //////////////////////////////

   localparam int cromMemCycle    = 0;
   localparam int cromLoadVma     = 1;
   localparam int cromARead       = 2;
   localparam int cromForceExec   = 3;
   localparam int cromFetchCycle  = 4;
   localparam int cromForceUser   = 5;
   localparam int cromPhysical    = 6;
   localparam int cromExtAddr     = 7;
   localparam int cromDpFunc      = 8;
   localparam int cromWait        = 9;
   localparam int cromBWrite      = 10;
   localparam int cromReadCycle   = 11;
   localparam int cromWrTestCycle = 12;
   localparam int cromWriteCycle  = 13;
   localparam int cromCacheInh    = 14;
   localparam int cromSpecEn      = 15;
   // Two-bit cycle source, then three-bit special function
   localparam int cromCycleSelLo  = 16;
   localparam int cromSpecSelLo   = 18;

   // Dispatch word fields
   localparam int dromVma         = 0;
   localparam int dromReadCycle   = 1;
   localparam int dromWrTestCycle = 2;
   localparam int dromWriteCycle  = 3;
   localparam int dromCondFunc    = 4;

   //////////////////////////////
   // VMA layout, shared with dp
   //////////////////////////////

   localparam int vmaUser     = 0;
   localparam int vmaExec     = 1;
   localparam int vmaFetch    = 2;
   localparam int vmaRead     = 3;
   localparam int vmaWrTest   = 4;
   localparam int vmaWrite    = 5;
   localparam int vmaExtd     = 6;
   localparam int vmaCacheInh = 7;
   localparam int vmaPhys     = 8;
   localparam int vmaPrev     = 9;
   localparam int vmaIo       = 10;
   localparam int vmaWru      = 11;
   localparam int vmaVect     = 12;
   localparam int vmaIoByte   = 13;

   // Memory cycle source
   typedef enum logic [cycleSelWidth-1:0] {
      cycMicro    = 2'd0,
      cycDataPath = 2'd1,
      cycDispatch = 2'd2,
      cycNone     = 2'd3
   } cycleSrcT;

   // Special function codes, upper codes unused
   typedef enum logic [specSelWidth-1:0] {
      specNone      = 3'd0,
      specClrCache  = 3'd1,
      specPrevious  = 3'd2,
      specLoadFlags = 3'd3
   } specSelT;

endpackage

//--- hw/vmaReg.sv
//////////////////////////////
// VMA register with address and flag load
// Memory cycle source select and load pulse
//////////////////////////////

`timescale 1ns/1ps

module vmaReg (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clken,
   input  logic [vmaPkg::cromWidth-1:0] crom,
   input  logic [vmaPkg::dromWidth-1:0] drom,
   input  logic [vmaPkg::wordWidth-1:0] dp,
   input  logic                         cpuExec,
   input  logic                         prevEn,
   input  logic                         flagUser,
   input  logic                         flagPcu,
   input  logic                         pageFail,
   output logic [vmaPkg::wordWidth-1:0] vmaOut,
   output logic                         vmaLoad,
   output logic                         writeEn
);

   import vmaPkg::*;

   //////////////////////////////
   // Microword decode
   //////////////////////////////

   specSelT  specSel;
   cycleSrcT cycleSel;
   logic     cacheSweep;
   logic     selPrevious;
   logic     vmaEn;
   logic     memEn;
   logic     userNext;
   logic     readEn;
   logic     wrTestEn;
   logic     cacheInhEn;

   assign specSel  = specSelT'(crom[cromSpecSelLo +: specSelWidth]);
   assign cycleSel = cycleSrcT'(crom[cromCycleSelLo +: cycleSelWidth]);

   // Cache sweep and previous context never occur together
   assign cacheSweep  = crom[cromSpecEn] && (specSel == specClrCache);
   assign selPrevious = crom[cromSpecEn] && (specSel == specPrevious);

   // VMA load condition
   assign vmaEn = (crom[cromMemCycle] && crom[cromLoadVma]) ||
                  (crom[cromMemCycle] && crom[cromARead] && drom[dromVma]) ||
                  cacheSweep;

   // Memory enable for the cycle bits
   assign memEn = (crom[cromMemCycle] && crom[cromWait]) ||
                  (crom[cromMemCycle] && crom[cromBWrite] && drom[dromCondFunc]);

   // User bit from the microword rules
   assign userNext = (!crom[cromForceExec] && flagUser && !cpuExec) ||
                     (crom[cromFetchCycle] && flagUser) ||
                     (prevEn && flagPcu) ||
                     (selPrevious && flagPcu) ||
                     crom[cromForceUser];

   //////////////////////////////
   // Cycle source select
   //////////////////////////////

   always_comb
   begin
      readEn     = 1'b0;
      wrTestEn   = 1'b0;
      writeEn    = 1'b0;
      cacheInhEn = 1'b0;
      case (cycleSel)
         cycMicro:
         begin
            readEn     = crom[cromReadCycle];
            wrTestEn   = crom[cromWrTestCycle];
            writeEn    = crom[cromWriteCycle];
            cacheInhEn = crom[cromCacheInh];
         end
         cycDataPath:
         begin
            readEn     = dp[vmaRead];
            wrTestEn   = dp[vmaWrTest];
            writeEn    = dp[vmaWrite];
            cacheInhEn = dp[vmaCacheInh];
         end
         // Dispatch has no cache-inhibit bit
         cycDispatch:
         begin
            readEn   = drom[dromReadCycle];
            wrTestEn = drom[dromWrTestCycle];
            writeEn  = drom[dromWriteCycle];
         end
         // No cycle, everything stays low
         default:
         begin
            readEn = 1'b0;
         end
      endcase
   end

   //////////////////////////////
   // VMA register
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         vmaOut <= '0;
      end
      else
      begin
         // Address and flag part
         if (clken && vmaEn && !pageFail)
         begin
            vmaOut[vmaExec] <= 1'b0;
            vmaOut[vmaExtd] <= crom[cromExtAddr];
            vmaOut[vmaAddrLo +: addrWidth] <= dp[vmaAddrLo +: addrWidth];
            if (crom[cromDpFunc])
            begin
               // Flags straight from the data path
               vmaOut[vmaUser]   <= dp[vmaUser];
               vmaOut[vmaFetch]  <= dp[vmaFetch];
               vmaOut[vmaPhys]   <= dp[vmaPhys];
               vmaOut[vmaPrev]   <= dp[vmaPrev];
               vmaOut[vmaIo]     <= dp[vmaIo];
               vmaOut[vmaWru]    <= dp[vmaWru];
               vmaOut[vmaVect]   <= dp[vmaVect];
               vmaOut[vmaIoByte] <= dp[vmaIoByte];
            end
            else
            begin
               vmaOut[vmaUser]   <= userNext;
               vmaOut[vmaFetch]  <= crom[cromFetchCycle];
               vmaOut[vmaPhys]   <= crom[cromPhysical];
               vmaOut[vmaPrev]   <= prevEn || selPrevious;
               vmaOut[vmaIo]     <= 1'b0;
               vmaOut[vmaWru]    <= 1'b0;
               vmaOut[vmaVect]   <= 1'b0;
               vmaOut[vmaIoByte] <= 1'b0;
            end
         end
         // Cycle bits latch under the memory enable
         if (clken && memEn && !pageFail)
         begin
            vmaOut[vmaRead]     <= readEn;
            vmaOut[vmaWrTest]   <= wrTestEn;
            vmaOut[vmaWrite]    <= writeEn;
            vmaOut[vmaCacheInh] <= cacheInhEn;
         end
      end
   end

   // Load pulse, one cycle after the request, not gated by clken
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         vmaLoad <= 1'b0;
      end
      else
      begin
         vmaLoad <= vmaEn;
      end
   end

endmodule

//--- hw/vmaTop.sv
//////////////////////////////
// VMA stage top level
//////////////////////////////

`timescale 1ns/1ps

module vmaTop #(
   parameter int pageIndexBits = 4
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clken,
   input  logic [vmaPkg::cromWidth-1:0] crom,
   input  logic [vmaPkg::dromWidth-1:0] drom,
   input  logic [vmaPkg::wordWidth-1:0] dp,
   input  logic                         cpuExec,
   input  logic                         prevEn,
   input  logic                         flagsLoad,
   input  logic                         pageWrite,
   input  logic [pageIndexBits-1:0]     pageIndex,
   input  logic                         pageValid,
   input  logic                         pageWritable,
   input  logic                         pageUserOk,
   output logic [vmaPkg::wordWidth-1:0] vmaOut,
   output logic                         vmaLoad,
   output logic                         writeEn,
   output logic                         pageFail
);

   // Flags into the VMA
   logic flagUser;
   logic flagPcu;

   pcFlags u_pcFlags (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .flagsLoad (flagsLoad),
      .crom      (crom),
      .dp        (dp),
      .flagUser  (flagUser),
      .flagPcu   (flagPcu)
   );

   vmaReg u_vmaReg (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .crom     (crom),
      .drom     (drom),
      .dp       (dp),
      .cpuExec  (cpuExec),
      .prevEn   (prevEn),
      .flagUser (flagUser),
      .flagPcu  (flagPcu),
      .pageFail (pageFail),
      .vmaOut   (vmaOut),
      .vmaLoad  (vmaLoad),
      .writeEn  (writeEn)
   );

   // Fault feeds back to block further loads
   pageCheck #(
      .pageIndexBits (pageIndexBits)
   ) u_pageCheck (
      .clk          (clk),
      .rst          (rst),
      .clken        (clken),
      .pageWrite    (pageWrite),
      .pageValid    (pageValid),
      .pageWritable (pageWritable),
      .pageUserOk   (pageUserOk),
      .pageIndex    (pageIndex),
      .vmaOut       (vmaOut),
      .vmaLoad      (vmaLoad),
      .pageFail     (pageFail)
   );

endmodule

//--- verification/vmaChecker.sv
//////////////////////////////
// VMA stage checker
// Reference rules and per-cycle compare
//////////////////////////////

`timescale 1ns/1ps

module vmaChecker #(
   parameter int pageIndexBits = 4
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clken,
   input  logic [vmaPkg::cromWidth-1:0] crom,
   input  logic [vmaPkg::dromWidth-1:0] drom,
   input  logic [vmaPkg::wordWidth-1:0] dp,
   input  logic                         cpuExec,
   input  logic                         prevEn,
   input  logic                         flagsLoad,
   input  logic                         pageWrite,
   input  logic [pageIndexBits-1:0]     pageIndex,
   input  logic                         pageValid,
   input  logic                         pageWritable,
   input  logic                         pageUserOk,
   input  logic [vmaPkg::wordWidth-1:0] vmaOut,
   input  logic                         vmaLoad,
   input  logic                         writeEn,
   input  logic                         pageFail,
   output int                           errorCount
);

   import vmaPkg::*;

   localparam int tableSize = 1 << pageIndexBits;
   localparam int pageNumLo = vmaAddrLo + pageOffsetBits;
   // Flag bits that a dp function copies
   localparam logic [wordWidth-1:0] dpFlagMask =
      (36'd1 << vmaUser) | (36'd1 << vmaFetch) | (36'd1 << vmaPhys) | (36'd1 << vmaPrev) |
      (36'd1 << vmaIo) | (36'd1 << vmaWru) | (36'd1 << vmaVect) | (36'd1 << vmaIoByte);

   // Model state
   logic [wordWidth-1:0]     expVma;
   logic                     expLoad;
   logic                     expFail;
   logic                     modelUser;
   logic                     modelPcu;
   logic [tableSize-1:0]     tValid;
   logic [tableSize-1:0]     tWritable;
   logic [tableSize-1:0]     tUserOk;
   logic [pageIndexBits-1:0] idx;
   logic                     nextFail;
   logic [3:0]               cycBits;
   int                       errors = 0;

   assign errorCount = errors;

   //////////////////////////////
   // Reference rules
   //////////////////////////////

   // Load-VMA, a-read with dispatch, or cache sweep
   function automatic logic loadCond(input logic [cromWidth-1:0] c,
                                     input logic [dromWidth-1:0] d);
      return (c[cromMemCycle] && (c[cromLoadVma] || (c[cromARead] && d[dromVma]))) ||
             (c[cromSpecEn] && (c[cromSpecSelLo +: specSelWidth] == specClrCache));
   endfunction

   function automatic logic memCond(input logic [cromWidth-1:0] c,
                                    input logic [dromWidth-1:0] d);
      return c[cromMemCycle] && (c[cromWait] || (c[cromBWrite] && d[dromCondFunc]));
   endfunction

   // Packed as cacheInh, write, wrTest, read
   function automatic logic [3:0] cycleRule(input logic [cromWidth-1:0] c,
                                            input logic [dromWidth-1:0] d,
                                            input logic [wordWidth-1:0] w);
      case (c[cromCycleSelLo +: cycleSelWidth])
         cycMicro:
            return {c[cromCacheInh], c[cromWriteCycle], c[cromWrTestCycle], c[cromReadCycle]};
         cycDataPath:
            return {w[vmaCacheInh], w[vmaWrite], w[vmaWrTest], w[vmaRead]};
         cycDispatch:
            return {1'b0, d[dromWriteCycle], d[dromWrTestCycle], d[dromReadCycle]};
         default:
            return 4'b0000;
      endcase
   endfunction

   // Address and flag part of a load
   function automatic logic [wordWidth-1:0] flagRule(input logic [wordWidth-1:0] oldVma,
                                                     input logic [cromWidth-1:0] c,
                                                     input logic [wordWidth-1:0] w,
                                                     input logic cpuE, prevE, fUser, fPcu);
      logic [wordWidth-1:0] v;
      logic                 prevFn;
      v = oldVma;
      prevFn = c[cromSpecEn] && (c[cromSpecSelLo +: specSelWidth] == specPrevious);
      v[wordWidth-1:vmaAddrLo] = w[wordWidth-1:vmaAddrLo];
      v[vmaExec] = 1'b0;
      v[vmaExtd] = c[cromExtAddr];
      if (c[cromDpFunc])
         v = (v & ~dpFlagMask) | (w & dpFlagMask);
      else
      begin
         v[vmaUser] = (!c[cromForceExec] && fUser && !cpuE) || (c[cromFetchCycle] && fUser) ||
                      (prevE && fPcu) || (prevFn && fPcu) || c[cromForceUser];
         v[vmaFetch] = c[cromFetchCycle];
         v[vmaPhys] = c[cromPhysical];
         v[vmaPrev] = prevE || prevFn;
         // io, wru, vect, ioByte
         v[vmaIoByte:vmaIo] = '0;
      end
      return v;
   endfunction

   // Virtual, non-io access against one table entry
   function automatic logic faultRule(input logic [wordWidth-1:0] v,
                                      input logic valid, writable, userOk);
      return !v[vmaPhys] && !v[vmaIo] &&
             (!valid || ((v[vmaWrite] || v[vmaWrTest]) && !writable) ||
              (v[vmaUser] && !userOk));
   endfunction

   task automatic checkValue(input string name, input logic [wordWidth-1:0] got,
                             input logic [wordWidth-1:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   //////////////////////////////
   // Compare and model update
   //////////////////////////////

   always @(posedge clk)
   begin
      if (rst)
      begin
         expVma    = '0;
         expLoad   = 1'b0;
         expFail   = 1'b0;
         modelUser = 1'b0;
         modelPcu  = 1'b0;
         tValid    = '0;
         tWritable = '0;
         tUserOk   = '0;
      end
      else
      begin
         // Outputs before this edge
         checkValue("vmaOut", vmaOut, expVma);
         checkValue("vmaLoad", vmaLoad, expLoad);
         checkValue("pageFail", pageFail, expFail);
         cycBits = cycleRule(crom, drom, dp);
         checkValue("writeEn", writeEn, cycBits[2]);
         // Fault uses the VMA as it stands now
         idx = expVma[pageNumLo +: pageIndexBits];
         nextFail = expFail;
         if (clken)
            nextFail = expLoad && faultRule(expVma, tValid[idx], tWritable[idx], tUserOk[idx]);
         if (clken && loadCond(crom, drom) && !expFail)
            expVma = flagRule(expVma, crom, dp, cpuExec, prevEn, modelUser, modelPcu);
         if (clken && memCond(crom, drom) && !expFail)
         begin
            expVma[vmaWrite:vmaRead] = cycBits[2:0];
            expVma[vmaCacheInh] = cycBits[3];
         end
         // Flags change after the load used the old ones
         if (clken && (flagsLoad || (crom[cromSpecEn] &&
             (crom[cromSpecSelLo +: specSelWidth] == specLoadFlags))))
         begin
            modelUser = dp[vmaUser];
            modelPcu  = dp[vmaPrev];
         end
         if (clken && pageWrite)
         begin
            tValid[pageIndex]    = pageValid;
            tWritable[pageIndex] = pageWritable;
            tUserOk[pageIndex]   = pageUserOk;
         end
         expLoad = loadCond(crom, drom);
         expFail = nextFail;
      end
   end

endmodule

//--- verification/vmaTb.sv
//////////////////////////////
// VMA stage testbench
// Directed cases, LCG random phase, report
//////////////////////////////

`timescale 1ns/1ps

module vmaTb;

   import vmaPkg::*;

   localparam int pageIndexBits = 4;
   // Memory cycle with load-VMA
   localparam logic [cromWidth-1:0] loadReq = (1 << cromMemCycle) | (1 << cromLoadVma);

   logic                     clk;
   logic                     rst;
   logic                     clken;
   logic [cromWidth-1:0]     crom;
   logic [dromWidth-1:0]     drom;
   logic [wordWidth-1:0]     dp;
   logic                     cpuExec;
   logic                     prevEn;
   logic                     flagsLoad;
   logic                     pageWrite;
   logic [pageIndexBits-1:0] pageIndex;
   logic                     pageValid;
   logic                     pageWritable;
   logic                     pageUserOk;
   logic [wordWidth-1:0]     vmaOut;
   logic                     vmaLoad;
   logic                     writeEn;
   logic                     pageFail;
   int                       errorCount;
   logic [31:0]              lcgState;
   int                       waitCount;
   int                       i;

   vmaTop #(.pageIndexBits(pageIndexBits)) u_vmaTop (
      .clk(clk), .rst(rst), .clken(clken), .crom(crom), .drom(drom), .dp(dp),
      .cpuExec(cpuExec), .prevEn(prevEn), .flagsLoad(flagsLoad), .pageWrite(pageWrite),
      .pageIndex(pageIndex), .pageValid(pageValid), .pageWritable(pageWritable),
      .pageUserOk(pageUserOk), .vmaOut(vmaOut), .vmaLoad(vmaLoad), .writeEn(writeEn),
      .pageFail(pageFail)
   );

   vmaChecker #(.pageIndexBits(pageIndexBits)) u_vmaChecker (
      .clk(clk), .rst(rst), .clken(clken), .crom(crom), .drom(drom), .dp(dp),
      .cpuExec(cpuExec), .prevEn(prevEn), .flagsLoad(flagsLoad), .pageWrite(pageWrite),
      .pageIndex(pageIndex), .pageValid(pageValid), .pageWritable(pageWritable),
      .pageUserOk(pageUserOk), .vmaOut(vmaOut), .vmaLoad(vmaLoad), .writeEn(writeEn),
      .pageFail(pageFail), .errorCount(errorCount)
   );

   // 20 ns clock
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Address in the given page, fixed word offset
   function automatic logic [wordWidth-1:0] pageAddr(input int page);
      return (36'(page) << (vmaAddrLo + pageOffsetBits)) | (36'h5A << vmaAddrLo);
   endfunction

   // Inputs move just after the edge
   task automatic step;
      @(posedge clk);
      #2;
   endtask

   task automatic timeoutFail(input string what);
      $display("Timeout: %s", what);
      $display("Done: errors found");
      $finish;
   endtask

   // Wait for vmaLoad or pageFail, bounded
   task automatic waitFor(input bit wantFail, input string what);
      waitCount = 0;
      do
      begin
         step;
         waitCount++;
      end
      while (!(wantFail ? pageFail : vmaLoad) && waitCount < 8);
      if (!(wantFail ? pageFail : vmaLoad))
         timeoutFail(what);
   endtask

   // Upper LCG bits only, low bits repeat quickly
   task automatic randomInputs;
      lcgState = lcgNext(lcgState);
      crom = lcgState[31:11];
      lcgState = lcgNext(lcgState);
      dp[35:18] = lcgState[31:14];
      drom = lcgState[13:9];
      lcgState = lcgNext(lcgState);
      dp[17:0] = lcgState[31:14];
      cpuExec = lcgState[13];
      prevEn = lcgState[12];
      clken = lcgState[11:9] != 3'd0;
      flagsLoad = lcgState[8:6] == 3'd0;
      lcgState = lcgNext(lcgState);
      pageWrite = lcgState[31:29] == 3'd0;
      pageIndex = lcgState[28:25];
      pageValid = lcgState[24:23] != 2'd0;
      pageWritable = lcgState[22];
      pageUserOk = lcgState[21];
   endtask

   initial
   begin
      lcgState = 32'd43;
      rst = 1'b1;
      clken = 1'b1;
      crom = '0;
      drom = '0;
      dp = '0;
      cpuExec = 1'b0;
      prevEn = 1'b0;
      flagsLoad = 1'b0;
      pageWrite = 1'b0;
      pageIndex = '0;
      pageValid = 1'b0;
      pageWritable = 1'b0;
      pageUserOk = 1'b0;
      repeat (8) @(posedge clk);
      #2 rst = 1'b0;

      // Open every page
      {pageWrite, pageValid, pageWritable, pageUserOk} = 4'b1111;
      for (i = 0; i < (1 << pageIndexBits); i++)
      begin
         pageIndex = i;
         step;
      end
      pageWrite = 1'b0;

      // Plain load after reset
      dp = pageAddr(3);
      crom = loadReq;
      waitFor(1'b0, "vmaLoad did not rise after a load request");

      // Each cycle source, write and read requested
      drom = 5'b01110;
      for (i = 0; i < 4; i++)
      begin
         crom = loadReq | (1 << cromWait) | (i << cromCycleSelLo) |
                (1 << cromWriteCycle) | (1 << cromReadCycle) | (1 << cromCacheInh);
         dp = pageAddr(i) | (36'd1 << vmaWrTest) | (36'd1 << vmaCacheInh);
         step;
      end

      // Clock enable low freezes the VMA
      clken = 1'b0;
      dp = pageAddr(9);
      crom = loadReq;
      repeat (3) step;
      clken = 1'b1;

      // User flag from flagsLoad, then from the load-flags function
      crom = '0;
      flagsLoad = 1'b1;
      dp = 36'd1 << vmaUser;
      step;
      flagsLoad = 1'b0;
      dp = pageAddr(4);
      crom = loadReq;
      waitFor(1'b0, "vmaLoad did not rise after the flag load");
      crom = (1 << cromSpecEn) | (specLoadFlags << cromSpecSelLo);
      dp = 36'd1 << vmaPrev;
      step;
      // Exec mode, so only the previous-context term can set user
      cpuExec = 1'b1;
      prevEn = 1'b1;
      dp = pageAddr(4);
      crom = loadReq;
      waitFor(1'b0, "vmaLoad did not rise after the load-flags function");
      prevEn = 1'b0;
      cpuExec = 1'b0;

      // Invalid page, request held through the fault
      crom = '0;
      {pageWrite, pageValid, pageIndex} = {1'b1, 1'b0, 4'd5};
      step;
      pageWrite = 1'b0;
      dp = pageAddr(5);
      crom = loadReq;
      waitFor(1'b1, "pageFail did not rise for an invalid page");
      // Drop the request so the fault clears
      crom = '0;
      repeat (2) step;
      // Physical access to the same page
      crom = loadReq | (1 << cromPhysical);
      repeat (4) step;

      // Random phase
      for (i = 0; i < 400; i++)
      begin
         randomInputs;
         step;
      end
      clken = 1'b1;
      crom = '0;
      pageWrite = 1'b0;
      flagsLoad = 1'b0;
      repeat (4) step;

      $display("Checks complete, %0d errors", errorCount);
      if (errorCount == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule
